// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_sha512
	./obj_dir/Vtb_sha512 | awk '{ print } /^Simulation passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: all.f
+incdir+source
+incdir+verification
source/sha512_pkg.sv
source/sha512_padder.sv
source/sha512_core.sv
source/sha512_wb_regs.sv
source/sha512_top.sv
verification/tb_sha512.sv

// File: source/sha512_core.sv
// SHA-512 compression core
// Loads a 1024-bit block as 32-bit words, runs one round per cycle with an
// on-the-fly message schedule and adds the result into the hash state
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512_core import sha512_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         blk_valid,
  input  logic         blk_first,
  input  sha512_word_t blk_word,
  output logic         core_busy,
  output logic [511:0] digest
);

  logic [4:0]    word_cnt;
  logic [4:0]    word_idx;
  logic [6:0]    round_cnt;
  logic          load_done;
  logic          in_round;
  logic          in_final;
  sha512_word_t  half_q;
  sha512_dword_t w_q [0:15];
  sha512_dword_t hash_q [0:7];
  sha512_dword_t work_q [0:7];
  sha512_dword_t k_t;
  sha512_dword_t w_new;
  sha512_dword_t t1;
  sha512_dword_t t2;

  function automatic sha512_dword_t rotr(input sha512_dword_t x, input int unsigned n);
    return (x >> n) | (x << (64 - n));
  endfunction

  function automatic sha512_dword_t big_s0(input sha512_dword_t x);
    return rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
  endfunction

  function automatic sha512_dword_t big_s1(input sha512_dword_t x);
    return rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
  endfunction

  function automatic sha512_dword_t small_s0(input sha512_dword_t x);
    return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  function automatic sha512_dword_t small_s1(input sha512_dword_t x);
    return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  // The first word of a message also realigns the word counter
  assign word_idx  = blk_first ? 5'd0 : word_cnt;
  assign load_done = blk_valid && (word_idx == 5'(`SHA512_BLOCK_WORDS - 1));
  assign in_round  = core_busy && (round_cnt < 7'(`SHA512_ROUNDS));
  assign in_final  = core_busy && (round_cnt == 7'(`SHA512_ROUNDS));

  always_comb begin
    k_t = '0;
    if (round_cnt < 7'(`SHA512_ROUNDS)) begin
      k_t = sha512_k[round_cnt];
    end
  end

  // The window always holds W(t) to W(t+15), so W(t+16) comes from fixed taps
  assign w_new = small_s1(w_q[14]) + w_q[9] + small_s0(w_q[1]) + w_q[0];

  // Working variables a to h sit in work_q[0] to work_q[7]
  assign t1 = work_q[7] + big_s1(work_q[4]) +
              ((work_q[4] & work_q[5]) ^ (~work_q[4] & work_q[6])) + k_t + w_q[0];
  assign t2 = big_s0(work_q[0]) +
              ((work_q[0] & work_q[1]) ^ (work_q[0] & work_q[2]) ^ (work_q[1] & work_q[2]));

  // Busy covers the 80 rounds and the feed-forward cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      word_cnt  <= '0;
      round_cnt <= '0;
      core_busy <= 1'b0;
    end else begin
      if (blk_valid) begin
        word_cnt <= word_idx + 5'd1;
      end
      if (load_done) begin
        core_busy <= 1'b1;
        round_cnt <= '0;
      end else if (in_final) begin
        core_busy <= 1'b0;
      end else if (in_round) begin
        round_cnt <= round_cnt + 7'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (blk_valid) begin
      if (blk_first) begin
        hash_q <= sha512_iv;
      end
      // Even words are the upper half of a dword
      if (!word_idx[0]) begin
        half_q <= blk_word;
      end else begin
        for (int i = 0; i < 15; i++) begin
          w_q[i] <= w_q[i + 1];
        end
        w_q[15] <= {half_q, blk_word};
      end
      if (load_done) begin
        work_q <= hash_q;
      end
    end else if (in_round) begin
      for (int i = 0; i < 15; i++) begin
        w_q[i] <= w_q[i + 1];
      end
      w_q[15]   <= w_new;
      work_q[7] <= work_q[6];
      work_q[6] <= work_q[5];
      work_q[5] <= work_q[4];
      work_q[4] <= work_q[3] + t1;
      work_q[3] <= work_q[2];
      work_q[2] <= work_q[1];
      work_q[1] <= work_q[0];
      work_q[0] <= t1 + t2;
    end else if (in_final) begin
      for (int i = 0; i < 8; i++) begin
        hash_q[i] <= hash_q[i] + work_q[i];
      end
    end
  end

  // H0 ends up in the most significant bits
  assign digest = {hash_q[0], hash_q[1], hash_q[2], hash_q[3],
                   hash_q[4], hash_q[5], hash_q[6], hash_q[7]};

endmodule

// File: source/sha512_defines.svh
// Widths, round count and Wishbone address map of the SHA-512 peripheral
`ifndef SHA512_DEFINES_SVH
`define SHA512_DEFINES_SVH

`define SHA512_WORD_W      32
`define SHA512_BLOCK_WORDS 32
`define SHA512_ROUNDS      80
`define SHA512_ADR_W       5
`define SHA512_ADR_CTRL    5'd0
`define SHA512_ADR_DATA    5'd1
`define SHA512_ADR_HASH    5'd16
`define SHA512_CTRL_START  0
`define SHA512_CTRL_END    1
`define SHA512_STAT_BUSY   0
`define SHA512_STAT_READY  1

`endif

// File: source/sha512_padder.sv
// Message sequencer of the SHA-512 peripheral
// Copies message words, appends the 1 bit, zero fill and 128-bit length,
// and streams whole 32-word blocks to the compression core
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512_padder import sha512_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             msg_start,
  input  logic             msg_end,
  input  logic             msg_valid,
  input  sha512_word_t     msg_data,
  input  sha512_byte_cnt_t msg_size,
  output logic             ready,
  output logic             busy,
  output logic             blk_valid,
  output logic             blk_first,
  output sha512_word_t     blk_word,
  input  logic             core_busy
);

  typedef enum logic [1:0] {ST_IDLE, ST_COPY, ST_WAIT, ST_PAD} state_t;

  state_t       state;
  state_t       state_next;
  logic [4:0]   word_cnt;
  logic [127:0] bit_len;
  logic         need_one;
  logic         closed;
  logic         ended;
  logic         end_pend;
  logic         first_pend;
  logic [6:0]   pad_left;
  logic         accept;
  logic         pad_emit;
  logic         chunk_done;
  logic         full_word;
  logic [5:0]   chunk_left;
  logic [6:0]   pad_total;
  sha512_word_t copy_word;
  sha512_word_t pad_word;

  // A partial word closes the copy phase, and a pending end must be served first
  assign ready      = (state == ST_COPY) && !core_busy && !closed && !end_pend;
  assign accept     = msg_valid && ready;
  assign pad_emit   = (state == ST_PAD) && !core_busy;
  assign chunk_done = word_cnt == 5'(`SHA512_BLOCK_WORDS - 1);
  assign full_word  = msg_size == 2'd3;
  assign busy       = state != ST_IDLE;

  // Words still free in this block, counted before the word being taken
  assign chunk_left = 6'(`SHA512_BLOCK_WORDS) - {1'b0, word_cnt};
  // Too little room for the 1 bit and the length words adds one more block
  assign pad_total  = (chunk_left < (full_word ? 6'd6 : 6'd5)) ?
                      {1'b0, chunk_left} + 7'(`SHA512_BLOCK_WORDS) :
                      {1'b0, chunk_left};

  // The 1 bit goes directly behind the last valid byte
  always_comb begin
    case (msg_size)
      2'd0:    copy_word = {msg_data[31:24], 1'b1, 23'd0};
      2'd1:    copy_word = {msg_data[31:16], 1'b1, 15'd0};
      2'd2:    copy_word = {msg_data[31:8], 1'b1, 7'd0};
      default: copy_word = msg_data;
    endcase
  end

  // The last four pad words carry the bit length, most significant first
  always_comb begin
    case (pad_left)
      7'd4:    pad_word = bit_len[127:96];
      7'd3:    pad_word = bit_len[95:64];
      7'd2:    pad_word = bit_len[63:32];
      7'd1:    pad_word = bit_len[31:0];
      default: pad_word = {need_one, 31'd0};
    endcase
  end

  // Accepted words pass to the core in the same cycle
  assign blk_valid = accept || pad_emit;
  assign blk_word  = pad_emit ? pad_word : copy_word;
  assign blk_first = blk_valid && first_pend;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: state_next = ST_IDLE;
      ST_COPY: begin
        if (end_pend) begin
          state_next = ST_PAD;
        end else if (accept && chunk_done) begin
          state_next = ST_WAIT;
        end
      end
      ST_WAIT: begin
        // Leave only once the core has finished the block
        if (!core_busy) begin
          if (!ended) begin
            state_next = ST_COPY;
          end else if (pad_left == 7'd0) begin
            state_next = ST_IDLE;
          end else begin
            state_next = ST_PAD;
          end
        end
      end
      ST_PAD: begin
        if (pad_emit && chunk_done) begin
          state_next = ST_WAIT;
        end
      end
      default: state_next = ST_IDLE;
    endcase
    // A start command restarts the sequencer from any state
    if (msg_start) begin
      state_next = ST_COPY;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= ST_IDLE;
      word_cnt   <= '0;
      bit_len    <= '0;
      need_one   <= 1'b1;
      closed     <= 1'b0;
      ended      <= 1'b0;
      end_pend   <= 1'b0;
      first_pend <= 1'b0;
      pad_left   <= '0;
    end else begin
      state <= state_next;
      if (msg_start) begin
        word_cnt   <= '0;
        bit_len    <= '0;
        need_one   <= 1'b1;
        closed     <= 1'b0;
        ended      <= 1'b0;
        end_pend   <= 1'b0;
        first_pend <= 1'b1;
        // An empty message pads one whole block
        pad_left   <= 7'(`SHA512_BLOCK_WORDS);
      end else begin
        // The end command may arrive during compression, so it is held until copy
        if (msg_end) begin
          end_pend <= 1'b1;
        end else if (state == ST_COPY && end_pend) begin
          end_pend <= 1'b0;
          ended    <= 1'b1;
        end
        if (blk_valid) begin
          word_cnt   <= word_cnt + 5'd1;
          first_pend <= 1'b0;
        end
        if (accept) begin
          bit_len  <= bit_len + {122'd0, ({1'b0, msg_size} + 3'd1), 3'b000};
          need_one <= full_word;
          closed   <= !full_word;
          pad_left <= pad_total - 7'd1;
        end
        if (pad_emit) begin
          need_one <= 1'b0;
          pad_left <= pad_left - 7'd1;
        end
      end
    end
  end

endmodule

// File: source/sha512_pkg.sv
// Word types shared by the SHA-512 blocks
// Round constants and initial hash value of FIPS 180-4
`include "sha512_defines.svh"

package sha512_pkg;

  // One Wishbone data word or one word of the block stream
  typedef logic [`SHA512_WORD_W-1:0] sha512_word_t;

  // Native algorithm word
  typedef logic [63:0] sha512_dword_t;

  // Valid bytes minus one, the valid bytes sit in the upper end of the word
  typedef logic [1:0] sha512_byte_cnt_t;

  // Round constants K0 to K79
  localparam sha512_dword_t sha512_k [0:79] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // Initial hash value H0 to H7
  localparam sha512_dword_t sha512_iv [0:7] = '{
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b,
    64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f,
    64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

endpackage

// File: source/sha512_top.sv
// Top level of the SHA-512 peripheral
// Wishbone slave, message padder and compression core
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512_top import sha512_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [`SHA512_ADR_W-1:0] adr,
  input  logic [3:0]               sel,
  input  sha512_word_t             dat_w,
  output sha512_word_t             dat_r,
  output logic                     ack
);

  logic             msg_start;
  logic             msg_end;
  logic             msg_valid;
  sha512_word_t     msg_data;
  sha512_byte_cnt_t msg_size;
  logic             ready;
  logic             busy;
  logic             blk_valid;
  logic             blk_first;
  sha512_word_t     blk_word;
  logic             core_busy;
  logic [511:0]     digest;

  sha512_wb_regs wb_regs0 (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .msg_start(msg_start), .msg_end(msg_end),
    .msg_valid(msg_valid), .msg_data(msg_data), .msg_size(msg_size),
    .ready(ready), .busy(busy), .digest(digest)
  );

  // Back-pressure from the core reaches the bus through the padder ready
  sha512_padder padder0 (
    .clk(clk), .rst(rst), .msg_start(msg_start), .msg_end(msg_end),
    .msg_valid(msg_valid), .msg_data(msg_data), .msg_size(msg_size),
    .ready(ready), .busy(busy), .blk_valid(blk_valid), .blk_first(blk_first),
    .blk_word(blk_word), .core_busy(core_busy)
  );

  sha512_core core0 (
    .clk(clk), .rst(rst), .blk_valid(blk_valid), .blk_first(blk_first),
    .blk_word(blk_word), .core_busy(core_busy), .digest(digest)
  );

endmodule

// File: source/sha512_wb_regs.sv
// Wishbone classic slave of the SHA-512 peripheral
// Decodes control, data, status and digest accesses
`timescale 1ns/1ps
`include "sha512_defines.svh"

module sha512_wb_regs import sha512_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [`SHA512_ADR_W-1:0] adr,
  input  logic [3:0]               sel,
  input  sha512_word_t             dat_w,
  output sha512_word_t             dat_r,
  output logic                     ack,
  output logic                     msg_start,
  output logic                     msg_end,
  output logic                     msg_valid,
  output sha512_word_t             msg_data,
  output sha512_byte_cnt_t         msg_size,
  input  logic                     ready,
  input  logic                     busy,
  input  logic [511:0]             digest
);

  logic         req;
  logic         adr_ctrl;
  logic         adr_data;
  logic         adr_hash;
  logic         ctrl_wr;
  logic         data_wr;
  logic         ack_next;
  logic [3:0]   hash_idx;
  sha512_word_t status;
  sha512_word_t rd_word;

  // The ack cycle itself is not a new request
  assign req      = cyc && stb && !ack;
  assign adr_ctrl = adr == `SHA512_ADR_CTRL;
  assign adr_data = adr == `SHA512_ADR_DATA;
  assign adr_hash = adr >= `SHA512_ADR_HASH;
  assign ctrl_wr  = req && we && adr_ctrl;
  assign data_wr  = req && we && adr_data;

  // Commands last only the single request cycle
  assign msg_start = ctrl_wr && dat_w[`SHA512_CTRL_START];
  assign msg_end   = ctrl_wr && dat_w[`SHA512_CTRL_END];
  assign msg_valid = data_wr;
  assign msg_data  = dat_w;

  // Leading set byte selects give the size of a tail word
  always_comb begin
    casez (sel)
      4'b1111: msg_size = 2'd3;
      4'b1110: msg_size = 2'd2;
      4'b110?: msg_size = 2'd1;
      default: msg_size = 2'd0;
    endcase
  end

  // Data writes stall until the padder takes the word
  assign ack_next = data_wr ? ready : req;

  always_comb begin
    status = '0;
    status[`SHA512_STAT_BUSY]  = busy;
    status[`SHA512_STAT_READY] = ready;
  end

  // Word 16 maps to the top of the digest
  assign hash_idx = ~adr[3:0];
  assign rd_word  = adr_hash ? digest[{hash_idx, 5'b00000} +: 32] :
                    adr_ctrl ? status : '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= ack_next;
    end
  end

  always_ff @(posedge clk) begin
    if (req && !we) begin
      dat_r <= rd_word;
    end
  end

endmodule

// File: verification/sha512_ref_model.svh
// Software SHA-512 reference for the testbench
// Pads a byte queue and compresses it block by block
function automatic sha512_dword_t rotr64(input sha512_dword_t x, input int n);
  return (x >> n) | (x << (64 - n));
endfunction

// Sigma functions of FIPS 180-4
function automatic sha512_dword_t bsig0(input sha512_dword_t x);
  return rotr64(x, 28) ^ rotr64(x, 34) ^ rotr64(x, 39);
endfunction

function automatic sha512_dword_t bsig1(input sha512_dword_t x);
  return rotr64(x, 14) ^ rotr64(x, 18) ^ rotr64(x, 41);
endfunction

function automatic sha512_dword_t ssig0(input sha512_dword_t x);
  return rotr64(x, 1) ^ rotr64(x, 8) ^ (x >> 7);
endfunction

function automatic sha512_dword_t ssig1(input sha512_dword_t x);
  return rotr64(x, 19) ^ rotr64(x, 61) ^ (x >> 6);
endfunction

// Appends 0x80, zero bytes up to 112 mod 128 and the 128-bit bit length
task automatic pad_message(input byte unsigned msg[$], output byte unsigned padded[$]);
  logic [127:0] bit_len;
  padded = msg;
  bit_len = {93'd0, 32'(msg.size()), 3'b000};
  padded.push_back(8'h80);
  while (padded.size() % 128 != 112) begin
    padded.push_back(8'h00);
  end
  // Length goes out most significant byte first
  for (int i = 15; i >= 0; i--) begin
    padded.push_back(bit_len[8*i +: 8]);
  end
endtask

task automatic compute_digest(input byte unsigned msg[$], output logic [511:0] dig);
  byte unsigned  padded[$];
  sha512_dword_t h [0:7];
  sha512_dword_t v [0:7];
  sha512_dword_t w [0:79];
  sha512_dword_t t1;
  sha512_dword_t t2;
  pad_message(msg, padded);
  h = sha512_iv;
  for (int b = 0; b < padded.size(); b += 128) begin
    // Big-endian dwords of this block, then the expanded schedule
    for (int t = 0; t < 16; t++) begin
      w[t] = '0;
      for (int k = 0; k < 8; k++) begin
        w[t] = {w[t][55:0], padded[b + 8*t + k]};
      end
    end
    for (int t = 16; t < 80; t++) begin
      w[t] = ssig1(w[t-2]) + w[t-7] + ssig0(w[t-15]) + w[t-16];
    end
    v = h;
    for (int t = 0; t < 80; t++) begin
      t1 = v[7] + bsig1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha512_k[t] + w[t];
      t2 = bsig0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--) begin
        v[i] = v[i-1];
      end
      v[4] = v[4] + t1;
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
      h[i] = h[i] + v[i];
    end
  end
  dig = {h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7]};
endtask

// File: verification/tb_sha512.sv
// Testbench of the SHA-512 peripheral
// Wishbone bus tasks, random messages, compare tasks and a watchdog
`timescale 1ns/1ps
`include "sha512_defines.svh"

module tb_sha512 import sha512_pkg::*; ();

  // abc, four padding boundaries, an empty message and eleven random messages
  localparam int NUM_MSGS = 17;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     cyc;
  logic                     stb;
  logic                     we;
  logic [`SHA512_ADR_W-1:0] adr;
  logic [3:0]               sel;
  sha512_word_t             dat_w;
  sha512_word_t             dat_r;
  logic                     ack;
  integer                   seed;

  `include "sha512_ref_model.svh"

  sha512_top dut0 (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
  );

  always #20 clk = ~clk;

  // Drives a cycle at edge plus 2 ns and samples ack and dat_r at edge plus 1 ns
  task automatic bus_transfer(input logic wr, input logic [`SHA512_ADR_W-1:0] a,
                              input sha512_word_t d, input logic [3:0] s,
                              output sha512_word_t q);
    cyc = 1'b1;
    stb = 1'b1;
    we = wr;
    adr = a;
    sel = s;
    dat_w = d;
    @(posedge clk);
    #1;
    while (!ack) begin
      @(posedge clk);
      #1;
    end
    q = dat_r;
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic wb_write(input logic [`SHA512_ADR_W-1:0] a, input sha512_word_t d,
                          input logic [3:0] s);
    sha512_word_t discard;
    bus_transfer(1'b1, a, d, s, discard);
  endtask

  task automatic wb_read(input logic [`SHA512_ADR_W-1:0] a, output sha512_word_t q);
    bus_transfer(1'b0, a, '0, 4'hf, q);
  endtask

  task automatic check_word(input string name, input sha512_word_t exp, input sha512_word_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Only the status bits under mask are compared
  task automatic check_status(input sha512_word_t exp, input sha512_word_t act,
                              input sha512_word_t mask);
    if ((act & mask) !== (exp & mask)) begin
      $display("ERR status expected %h actual %h", exp & mask, act & mask);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic random_message(input int len, output byte unsigned msg[$]);
    msg.delete();
    for (int i = 0; i < len; i++) begin
      msg.push_back(8'($random(seed)));
    end
  endtask

  // Sends one message and compares all sixteen digest words with the model
  task automatic hash_message(input byte unsigned msg[$]);
    logic [511:0] exp;
    sha512_word_t rd;
    sha512_word_t w;
    int           n;
    compute_digest(msg, exp);
    wb_write(`SHA512_ADR_CTRL, 32'd1 << `SHA512_CTRL_START, 4'hf);
    // A fresh message with an idle core is busy and takes words
    wb_read(`SHA512_ADR_CTRL, rd);
    check_status(32'h3, rd, 32'h3);
    for (int i = 0; i < msg.size(); i += 4) begin
      n = (msg.size() - i > 4) ? 4 : msg.size() - i;
      w = '0;
      for (int j = 0; j < n; j++) begin
        w[31 - 8*j -: 8] = msg[i + j];
      end
      // Valid bytes sit at the top, so a tail selects the upper lanes
      wb_write(`SHA512_ADR_DATA, w, 4'(4'hf << (4 - n)));
    end
    // Still busy until the end command
    wb_read(`SHA512_ADR_CTRL, rd);
    check_status(32'h1, rd, 32'h1);
    wb_write(`SHA512_ADR_CTRL, 32'd1 << `SHA512_CTRL_END, 4'hf);
    do begin
      wb_read(`SHA512_ADR_CTRL, rd);
    end while (rd[`SHA512_STAT_BUSY]);
    for (int i = 0; i < 16; i++) begin
      wb_read(5'(`SHA512_ADR_HASH + i), rd);
      check_word($sformatf("dat_r hash word %0d", i), exp[511 - 32*i -: 32], rd);
    end
  endtask

  initial begin
    byte unsigned msg[$];
    sha512_word_t rd;
    int           boundary [4];
    seed = 32'h909ba6da;
    boundary = '{111, 112, 127, 128};
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    sel = '0;
    dat_w = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    wb_read(`SHA512_ADR_CTRL, rd);
    check_status(32'h0, rd, 32'h3);
    msg = '{8'h61, 8'h62, 8'h63};
    hash_message(msg);
    // One extra block is needed from 112 bytes on
    for (int i = 0; i < 4; i++) begin
      random_message(boundary[i], msg);
      hash_message(msg);
    end
    // After a padded message only the start command brings the 1 bit back
    msg.delete();
    hash_message(msg);
    // No reset in between, so every start must clear the length and the pending one
    // The tail of the last word cycles through one to four bytes
    for (int i = 0; i < NUM_MSGS - 6; i++) begin
      random_message(($unsigned($random(seed)) % 75) * 4 + 1 + (i % 4), msg);
      hash_message(msg);
    end
    $display("Simulation passed");
    $finish;
  end

  // Three blocks of at most 200 cycles for every message
  initial begin
    #(NUM_MSGS * 3 * 200 * 40);
    $display("Timeout: the hash never completed in the allowed time");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule
